/* uart_pkg.sv */
package uart_pkg;

  // Bus and serial vector types.
  typedef logic [7:0]  byte_t;   // One serial data byte.
  typedef logic [31:0] word_t;   // Bus data word.
  typedef logic [31:0] addr_t;   // Bus byte address.
  typedef logic [3:0]  strb_t;   // Byte write strobes.
  typedef logic [15:0] count_t;  // Bit period counter.

  // Register offsets, matched against address bits 3 to 0.
  localparam logic [3:0] data_offset   = 4'h0;  // Transmit on write, receive on read.
  localparam logic [3:0] status_offset = 4'h4;  // Status on read, flag clear on write.

  // Status word bit positions.
  localparam int status_tx_busy   = 0;  // Frame in progress on the tx line.
  localparam int status_rx_avail  = 1;  // Receive FIFO holds at least one byte.
  localparam int status_overrun   = 2;  // Sticky, a byte was dropped.
  localparam int status_frame_err = 3;  // Sticky, a stop bit sampled low.

  // Frame layout, 8N1.
  localparam int frame_bits = 10;  // Start, eight data, stop.

endpackage

/* uart_tx.sv */
`timescale 1ns/10ps

module uart_tx #(
  parameter int unsigned clks_per_bit = 16
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            tx_start,
  input  uart_pkg::byte_t tx_byte,
  output logic            tx_busy,
  output logic            tx_done,
  output logic            serial_tx
);
  import uart_pkg::*;

  typedef enum logic {
    tx_idle,
    tx_shift
  } tx_state_t;

  localparam count_t last_count = count_t'(clks_per_bit - 1);
  localparam logic [3:0] last_bit = 4'(frame_bits - 1);

  tx_state_t   state;
  logic [9:0]  shift_reg;  // Bit 0 is on the line.
  count_t      count;
  logic [3:0]  bit_index;
  logic        period_end;

  assign period_end = (count == last_count);
  assign serial_tx  = shift_reg[0];
  assign tx_busy    = (state == tx_shift);
  assign tx_done    = (state == tx_shift) && period_end && (bit_index == last_bit);

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= tx_idle;
      shift_reg <= '1;
      count     <= '0;
      bit_index <= '0;
    end else begin
      case (state)
        tx_idle: begin
          if (tx_start) begin
            shift_reg <= {1'b1, tx_byte, 1'b0};  // Stop, data LSB first, start.
            count     <= '0;
            bit_index <= '0;
            state     <= tx_shift;
          end
        end
        tx_shift: begin
          if (period_end) begin
            count <= '0;
            if (bit_index == last_bit) begin
              shift_reg <= '1;  // Line idles high.
              state     <= tx_idle;
            end else begin
              shift_reg <= {1'b1, shift_reg[9:1]};
              bit_index <= bit_index + 4'd1;
            end
          end else begin
            count <= count + count_t'(1);
          end
        end
        default: begin
          state <= tx_idle;
        end
      endcase
    end
  end

endmodule

/* uart_rx.sv */
`timescale 1ns/10ps

module uart_rx #(
  parameter int unsigned clks_per_bit = 16
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            serial_rx,
  output logic            rx_strobe,
  output uart_pkg::byte_t rx_byte,
  output logic            rx_frame_err
);
  import uart_pkg::*;

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_t;

  localparam count_t half_count = count_t'(clks_per_bit / 2 - 1);
  localparam count_t last_count = count_t'(clks_per_bit - 1);
  localparam count_t hold_count = count_t'(clks_per_bit);  // Marks a low stop bit.

  rx_state_t  state;
  logic       rx_meta;
  logic       rx_sync;
  count_t     count;
  logic [2:0] bit_index;
  byte_t      data_reg;

  assign rx_byte = data_reg;

  always_ff @(posedge clock) begin
    if (reset) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= serial_rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clock) begin
    if (state == rx_data && count == last_count) begin
      data_reg <= {rx_sync, data_reg[7:1]};  // LSB arrives first.
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= rx_idle;
      count        <= '0;
      bit_index    <= '0;
      rx_strobe    <= 1'b0;
      rx_frame_err <= 1'b0;
    end else begin
      rx_strobe    <= 1'b0;
      rx_frame_err <= 1'b0;
      case (state)
        rx_idle: begin
          count     <= '0;
          bit_index <= '0;
          if (!rx_sync) begin
            state <= rx_start;
          end
        end
        rx_start: begin
          if (count == half_count) begin
            count <= '0;
            state <= rx_sync ? rx_idle : rx_data;  // High here was a glitch.
          end else begin
            count <= count + count_t'(1);
          end
        end
        rx_data: begin
          if (count == last_count) begin
            count     <= '0;
            bit_index <= bit_index + 3'd1;
            if (bit_index == 3'd7) begin
              state <= rx_stop;
            end
          end else begin
            count <= count + count_t'(1);
          end
        end
        rx_stop: begin
          if (count == last_count) begin
            if (rx_sync) begin
              rx_strobe <= 1'b1;
              state     <= rx_idle;
            end else begin
              rx_frame_err <= 1'b1;
              count        <= hold_count;
            end
          end else if (count == hold_count) begin
            // Wait for the line to return high before looking for a new start bit.
            if (rx_sync) begin
              state <= rx_idle;
            end
          end else begin
            count <= count + count_t'(1);
          end
        end
        default: begin
          state <= rx_idle;
        end
      endcase
    end
  end

endmodule

/* uart_fifo.sv */
`timescale 1ns/10ps

module uart_fifo #(
  parameter int unsigned fifo_depth = 4
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            push,
  input  uart_pkg::byte_t push_byte,
  input  logic            pop,
  output uart_pkg::byte_t pop_byte,
  output logic            empty,
  output logic            overrun
);
  import uart_pkg::*;

  localparam int ptr_w   = $clog2(fifo_depth);
  localparam int count_w = $clog2(fifo_depth + 1);

  byte_t              mem [fifo_depth];
  logic [ptr_w-1:0]   wr_ptr;
  logic [ptr_w-1:0]   rd_ptr;
  logic [count_w-1:0] count;
  logic               full;
  logic               do_push;

  assign full     = (count == count_w'(fifo_depth));
  assign empty    = (count == '0);
  assign do_push  = push && !full;
  assign pop_byte = mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= push_byte;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      overrun <= 1'b0;
    end else begin
      overrun <= push && full;  // Byte is dropped.
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;  // Wraps, depth is a power of two.
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* uart_bus.sv */
`timescale 1ns/10ps

module uart_bus (
  input  logic            clock,
  input  logic            reset,
  input  logic            bus_valid,
  input  uart_pkg::addr_t bus_addr,
  input  uart_pkg::word_t bus_wdata,
  input  uart_pkg::strb_t bus_wstrb,
  input  logic            tx_busy,
  input  logic            tx_done,
  input  uart_pkg::byte_t pop_byte,
  input  logic            empty,
  input  logic            overrun,
  input  logic            rx_frame_err,
  output uart_pkg::word_t bus_rdata,
  output logic            bus_ready,
  output logic            tx_start,
  output uart_pkg::byte_t tx_byte,
  output logic            pop
);
  import uart_pkg::*;

  typedef enum logic [1:0] {
    bus_idle,
    bus_wait_tx,
    bus_wait_rx,
    bus_respond
  } bus_state_t;

  bus_state_t state;
  logic       tx_sent;  // Our frame has been started.
  logic       overrun_flag;
  logic       frame_err_flag;
  logic       is_write;
  logic [3:0] offset;
  word_t      status_word;

  assign is_write = |bus_wstrb;
  assign offset   = bus_addr[3:0];

  always_comb begin
    status_word                   = '0;
    status_word[status_tx_busy]   = tx_busy;
    status_word[status_rx_avail]  = !empty;
    status_word[status_overrun]   = overrun_flag;
    status_word[status_frame_err] = frame_err_flag;
  end

  assign tx_start  = (state == bus_wait_tx) && !tx_sent && !tx_busy;
  assign tx_byte   = bus_wdata[7:0];
  assign pop       = (state == bus_wait_rx) && !empty;
  assign bus_ready = (state == bus_respond) || pop ||
                     ((state == bus_wait_tx) && tx_sent && tx_done);

  always_comb begin
    bus_rdata = '0;
    if (state == bus_wait_rx) begin
      bus_rdata = word_t'(pop_byte);  // Zero-extended.
    end else if (state == bus_respond && offset == status_offset && !is_write) begin
      bus_rdata = status_word;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state          <= bus_idle;
      tx_sent        <= 1'b0;
      overrun_flag   <= 1'b0;
      frame_err_flag <= 1'b0;
    end else begin
      case (state)
        bus_idle: begin
          if (bus_valid) begin
            if (offset != data_offset) begin
              state <= bus_respond;
            end else if (is_write) begin
              state <= bus_wait_tx;
            end else begin
              state <= bus_wait_rx;
            end
          end
        end
        bus_wait_tx: begin
          if (tx_start) begin
            tx_sent <= 1'b1;
          end
          if (bus_ready) begin
            tx_sent <= 1'b0;
            state   <= bus_idle;
          end
        end
        bus_wait_rx: begin
          if (pop) begin
            state <= bus_idle;
          end
        end
        default: begin
          state <= bus_idle;  // Respond lasts one cycle.
        end
      endcase
      if (state == bus_respond && is_write && offset == status_offset) begin
        overrun_flag   <= 1'b0;
        frame_err_flag <= 1'b0;
      end
      if (overrun) begin
        overrun_flag <= 1'b1;  // A new event wins over a clear.
      end
      if (rx_frame_err) begin
        frame_err_flag <= 1'b1;
      end
    end
  end

endmodule

/* uart_top.sv */
`timescale 1ns/10ps

module uart_top #(
  parameter int unsigned clks_per_bit = 16,
  parameter int unsigned fifo_depth   = 4
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            bus_valid,
  input  uart_pkg::addr_t bus_addr,
  input  uart_pkg::word_t bus_wdata,
  input  uart_pkg::strb_t bus_wstrb,
  input  logic            serial_rx,
  output uart_pkg::word_t bus_rdata,
  output logic            bus_ready,
  output logic            serial_tx
);
  import uart_pkg::*;

  logic  tx_start;
  logic  tx_busy;
  logic  tx_done;
  byte_t tx_byte;
  logic  rx_strobe;
  logic  rx_frame_err;
  byte_t rx_byte;
  logic  pop;
  byte_t pop_byte;
  logic  empty;
  logic  overrun;

  uart_bus u_uart_bus (
    .clock        (clock),
    .reset        (reset),
    .bus_valid    (bus_valid),
    .bus_addr     (bus_addr),
    .bus_wdata    (bus_wdata),
    .bus_wstrb    (bus_wstrb),
    .tx_busy      (tx_busy),
    .tx_done      (tx_done),
    .pop_byte     (pop_byte),
    .empty        (empty),
    .overrun      (overrun),
    .rx_frame_err (rx_frame_err),
    .bus_rdata    (bus_rdata),
    .bus_ready    (bus_ready),
    .tx_start     (tx_start),
    .tx_byte      (tx_byte),
    .pop          (pop)
  );

  uart_tx #(
    .clks_per_bit (clks_per_bit)
  ) u_uart_tx (
    .clock     (clock),
    .reset     (reset),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_busy   (tx_busy),
    .tx_done   (tx_done),
    .serial_tx (serial_tx)
  );

  uart_rx #(
    .clks_per_bit (clks_per_bit)
  ) u_uart_rx (
    .clock        (clock),
    .reset        (reset),
    .serial_rx    (serial_rx),
    .rx_strobe    (rx_strobe),
    .rx_byte      (rx_byte),
    .rx_frame_err (rx_frame_err)
  );

  uart_fifo #(
    .fifo_depth (fifo_depth)
  ) u_uart_fifo (
    .clock     (clock),
    .reset     (reset),
    .push      (rx_strobe),
    .push_byte (rx_byte),
    .pop       (pop),
    .pop_byte  (pop_byte),
    .empty     (empty),
    .overrun   (overrun)
  );

endmodule

/* uart_props.sv */
`timescale 1ns/10ps

module uart_props (
  input logic clock,
  input logic reset,
  input logic bus_valid,
  input logic bus_ready,
  input logic tx_busy,
  input logic serial_tx
);

  int unsigned fail_count = 0;

  ready_with_valid: assert property (
    @(posedge clock) disable iff (reset) bus_ready |-> bus_valid
  ) else begin
    $error("bus_ready high while bus_valid is low");
    fail_count++;
  end

  // Each access completes in exactly one ready cycle.
  ready_single_pulse: assert property (
    @(posedge clock) disable iff (reset) bus_ready |=> !bus_ready
  ) else begin
    $error("bus_ready held high for more than one cycle");
    fail_count++;
  end

  tx_idle_high: assert property (
    @(posedge clock) disable iff (reset) !tx_busy |-> serial_tx
  ) else begin
    $error("serial_tx low while the transmitter is idle");
    fail_count++;
  end

endmodule

bind uart_top uart_props u_uart_props (
  .clock     (clock),
  .reset     (reset),
  .bus_valid (bus_valid),
  .bus_ready (bus_ready),
  .tx_busy   (tx_busy),
  .serial_tx (serial_tx)
);

/* uart_tb.sv */
`timescale 1ns/10ps

module uart_tb;
  import uart_pkg::*;

  localparam int unsigned clks_per_bit = 8;
  localparam int unsigned fifo_depth   = 4;
  localparam int unsigned clock_ns     = 40;
  localparam addr_t       uart_base    = 32'h4000_1000;
  localparam int unsigned frame_cycles = 11 * clks_per_bit;  // Frame plus one idle bit.
  localparam int unsigned total_frames = 8 + 6 + 6 + 2 + 1;
  localparam int unsigned watchdog_ns  = 2 * total_frames * frame_cycles * clock_ns;

  logic  clock;
  logic  reset;
  logic  bus_valid;
  addr_t bus_addr;
  word_t bus_wdata;
  strb_t bus_wstrb;
  logic  serial_rx;
  word_t bus_rdata;
  logic  bus_ready;
  logic  serial_tx;
  logic  serial_drive;
  logic  loopback;

  integer      seed = 32'h91b7_7a13;
  int unsigned cycle_count = 0;
  int unsigned last_ready_cycle;
  int unsigned stop_cycle;
  int unsigned error_count = 0;
  int unsigned checks_pushed = 0;
  int unsigned checks_done = 0;
  int unsigned tests_run = 0;
  int unsigned test_first_error = 0;
  int unsigned test_first_check = 0;

  byte_t       model_q[$];  // Bytes the FIFO should hold.
  logic        model_dropped;
  logic        model_frame_bad;
  string       name_q[$];
  word_t       exp_q[$];
  word_t       got_q[$];
  byte_t       mon_byte_q[$];  // Frames decoded from serial_tx.
  logic        mon_stop_q[$];
  int unsigned mon_start_q[$];

  assign serial_rx = loopback ? serial_tx : serial_drive;

  uart_top #(
    .clks_per_bit (clks_per_bit),
    .fifo_depth   (fifo_depth)
  ) u_uart_top (
    .clock     (clock),
    .reset     (reset),
    .bus_valid (bus_valid),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_wstrb (bus_wstrb),
    .serial_rx (serial_rx),
    .bus_rdata (bus_rdata),
    .bus_ready (bus_ready),
    .serial_tx (serial_tx)
  );

  initial begin : clock_gen
    clock = 1'b0;
    forever begin
      #(clock_ns / 2) clock = ~clock;
    end
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
  end

  function automatic word_t ref_status(input int unsigned unread, input logic dropped,
                                       input logic frame_bad, input logic busy);
    word_t status;
    status    = '0;
    status[0] = busy;
    status[1] = (unread != 0);  // Something waits to be read.
    status[2] = dropped;
    status[3] = frame_bad;
    return status;
  endfunction

  task automatic expect_value(input string name, input word_t expected, input word_t actual);
    name_q.push_back(name);
    exp_q.push_back(expected);
    got_q.push_back(actual);
    checks_pushed++;
  endtask

  task automatic model_receive(input byte_t data);
    if (model_q.size() < fifo_depth) begin
      model_q.push_back(data);
    end else begin
      model_dropped = 1'b1;  // FIFO full, byte lost.
    end
  endtask

  task automatic bus_cycle(input addr_t addr, input word_t wdata, input strb_t wstrb,
                           output word_t rdata);
    @(negedge clock);
    bus_valid = 1'b1;
    bus_addr  = addr;
    bus_wdata = wdata;
    bus_wstrb = wstrb;
    do begin
      @(negedge clock);
    end while (!bus_ready);
    rdata            = bus_rdata;
    last_ready_cycle = cycle_count;
    @(negedge clock);  // Handshake took place on the rising edge.
    bus_valid = 1'b0;
    bus_wstrb = '0;
  endtask

  task automatic bus_write(input addr_t addr, input word_t data);
    word_t unused;
    bus_cycle(addr, data, 4'hf, unused);
  endtask

  task automatic bus_read(input addr_t addr, output word_t data);
    bus_cycle(addr, '0, 4'h0, data);
  endtask

  task automatic send_frame(input byte_t data, input logic stop_level);
    int i;
    @(negedge clock);
    serial_drive = 1'b0;
    repeat (clks_per_bit) @(negedge clock);
    for (i = 0; i < 8; i++) begin
      serial_drive = data[i];  // LSB first.
      repeat (clks_per_bit) @(negedge clock);
    end
    serial_drive = stop_level;
    stop_cycle   = cycle_count;
    repeat (clks_per_bit) @(negedge clock);
    serial_drive = 1'b1;
    repeat (clks_per_bit) @(negedge clock);
  endtask

  task automatic check_status(input string name);
    word_t rd;
    bus_read(uart_base + status_offset, rd);
    expect_value(name, ref_status(model_q.size(), model_dropped, model_frame_bad, 1'b0), rd);
  endtask

  task automatic check_read(input string name);
    word_t rd;
    word_t expected;
    expected = word_t'(model_q.pop_front());
    bus_read(uart_base + data_offset, rd);
    expect_value(name, expected, rd);
  endtask

  task automatic close_test(input string name);
    wait (checks_done == checks_pushed);
    if (error_count == test_first_error) begin
      $display("%s: passed, %0d checks", name, checks_done - test_first_check);
    end else begin
      $display("%s: failed, %0d errors", name, error_count - test_first_error);
    end
    tests_run++;
    test_first_error = error_count;
    test_first_check = checks_done;
  endtask

  initial begin : compare_results
    string name;
    word_t expected;
    word_t actual;
    forever begin
      wait (got_q.size() != 0);
      name     = name_q.pop_front();
      expected = exp_q.pop_front();
      actual   = got_q.pop_front();
      assert (actual === expected) else begin
        $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        error_count++;
      end
      checks_done++;
    end
  end

  initial begin : tx_monitor
    byte_t       data;
    int unsigned start;
    int          i;
    forever begin
      @(negedge clock);
      if (!reset && serial_tx === 1'b0) begin
        start = cycle_count;
        repeat (clks_per_bit / 2) @(negedge clock);  // Middle of the start bit.
        assert (serial_tx === 1'b0) else begin
          $display("[ERROR] tx monitor: start bit went high before its middle");
          error_count++;
        end
        for (i = 0; i < 8; i++) begin
          repeat (clks_per_bit) @(negedge clock);
          data[i] = serial_tx;
        end
        repeat (clks_per_bit) @(negedge clock);
        mon_stop_q.push_back(serial_tx);
        mon_byte_q.push_back(data);
        mon_start_q.push_back(start);
      end
    end
  end

  initial begin : watchdog
    #(watchdog_ns);
    $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
    $display("TEST FAIL");
    $finish;
  end

  initial begin : run_tests
    word_t wr;
    byte_t data;
    int    i;
    int    round;
    reset           = 1'b1;
    bus_valid       = 1'b0;
    bus_addr        = '0;
    bus_wdata       = '0;
    bus_wstrb       = '0;
    serial_drive    = 1'b1;
    loopback        = 1'b0;
    model_dropped   = 1'b0;
    model_frame_bad = 1'b0;
    repeat (4) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);

    expect_value("idle serial_tx", 1, word_t'(serial_tx));
    expect_value("idle bus_ready", 0, word_t'(bus_ready));
    check_status("idle status");
    close_test("idle_after_reset");

    mon_byte_q.delete();
    mon_stop_q.delete();
    mon_start_q.delete();
    for (i = 0; i < 8; i++) begin
      wr = word_t'($random(seed));
      bus_write(uart_base + data_offset, wr);
      expect_value("transmit frames decoded", 1, mon_byte_q.size());
      if (mon_byte_q.size() != 0) begin
        expect_value("transmit byte", word_t'(wr[7:0]), word_t'(mon_byte_q.pop_front()));
        expect_value("transmit stop bit", 1, word_t'(mon_stop_q.pop_front()));
        expect_value("transmit frame length", 10 * clks_per_bit,
                     last_ready_cycle - mon_start_q.pop_front() + 1);
      end
    end
    close_test("transmit");

    loopback = 1'b1;
    for (round = 0; round < 2; round++) begin
      for (i = 0; i < 3; i++) begin
        wr = word_t'($random(seed));
        bus_write(uart_base + data_offset, wr);
        model_receive(wr[7:0]);
        check_status("loopback status after write");
      end
      for (i = 0; i < 3; i++) begin
        check_read("loopback read");
        check_status("loopback status after read");
      end
    end
    loopback = 1'b0;
    close_test("loopback_receive");

    for (i = 0; i < 6; i++) begin
      data = byte_t'($random(seed));
      send_frame(data, 1'b1);
      model_receive(data);
    end
    check_status("overrun status");
    for (i = 0; i < 4; i++) begin
      check_read("overrun read");
    end
    check_status("overrun status after reads");
    bus_write(uart_base + status_offset, '0);
    model_dropped = 1'b0;
    check_status("overrun status after clear");
    close_test("overrun");

    data = byte_t'($random(seed));
    send_frame(data, 1'b0);
    model_frame_bad = 1'b1;
    check_status("frame error status");
    data = byte_t'($random(seed));
    send_frame(data, 1'b1);
    model_receive(data);
    check_status("status after good frame");
    check_read("read after frame error");
    bus_write(uart_base + status_offset, '0);
    model_frame_bad = 1'b0;
    check_status("frame error status after clear");
    close_test("framing_error");

    data = byte_t'($random(seed));
    model_receive(data);
    fork
      check_read("blocking read data");
      begin
        repeat (2 * clks_per_bit) @(negedge clock);
        send_frame(data, 1'b1);
      end
    join
    expect_value("blocking read after stop bit", 1, word_t'(last_ready_cycle > stop_cycle));
    close_test("blocking_read");

    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d", tests_run,
             checks_done, error_count, u_uart_top.u_uart_props.fail_count);
    if (error_count == 0 && u_uart_top.u_uart_props.fail_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* uart_subsys.f */
uart_pkg.sv
uart_tx.sv
uart_rx.sv
uart_fifo.sv
uart_bus.sv
uart_top.sv
uart_props.sv
uart_tb.sv

/* Bender.yml */
package:
  name: uart_subsys

sources:
  - uart_pkg.sv
  - uart_tx.sv
  - uart_rx.sv
  - uart_fifo.sv
  - uart_bus.sv
  - uart_top.sv
  - target: test
    files:
      - uart_props.sv
      - uart_tb.sv
